//--- bench/set_cache_dir_tb.sv
// testbench of the set associative tag directory
// directed tests and a random stream, each response checked against a reference model
// inputs driven on the falling edge where outputs are sampled first
module set_cache_dir_tb import cache_geom_pkg::*, cache_msg_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          RESET_CYCLES = 16;
	localparam int          RANDOM_REQS  = 400;
	localparam int          RUN_CYCLES   = RESET_CYCLES + 16 + 10 + 10 + 6 + 10 +
		2 * RANDOM_REQS;
	localparam int          MARGIN       = 200;	// cycles
	localparam logic [31:0] SEED         = 32'hf4dd_a254;

	logic  clock_i;
	logic  resetn_i;
	logic  req_valid_i;
	req_t  req_i;
	logic  resp_valid_o;
	resp_t resp_o;

	// reference model updated in request order
	tag_t        model_tag   [N_GROUPS][N_WAYS];
	logic        model_valid [N_GROUPS][N_WAYS];
	int          model_ptr   [N_GROUPS];
	logic        exp_valid_q [$];		// one entry per cycle
	resp_t       exp_resp_q  [$];
	int          errors;
	int          checks;
	logic [31:0] lcg_state;

	set_cache_dir dut (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.resp_valid_o (resp_valid_o),
		.resp_o       (resp_o)
	);

	always #20 clock_i = ~clock_i;

	// ------------------------------------------------------------------------
	// helpers
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic resp_t make_resp(input logic hit, input int way, input int grp,
			input logic ev, input tag_t etag);
		resp_t r;
		r.hit         = hit;
		r.addr        = {way_t'(way), group_t'(grp)};	// {way, group}
		r.evict_valid = ev;
		r.evict_tag   = etag;
		return r;
	endfunction

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_resp(input string name, input resp_t got, input resp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// hit on a valid matching way, else allocate at the fifo pointer
	task automatic model_step(input req_t req, output resp_t exp);
		int g;
		int hit_w;
		int p;
		g     = int'(req.group);
		hit_w = -1;
		for (int w = 0; w < N_WAYS; w++)
			if (model_valid[g][w] && model_tag[g][w] == req.tag)
				hit_w = w;
		p   = model_ptr[g];
		exp = '0;
		if (hit_w >= 0)
			exp = make_resp(1'b1, hit_w, g, 1'b0, '0);
		else begin
			exp = make_resp(1'b0, p, g, model_valid[g][p],
				model_valid[g][p] ? model_tag[g][p] : '0);
			model_tag[g][p]   = req.tag;
			model_valid[g][p] = 1'b1;
			model_ptr[g]      = (p + 1) % N_WAYS;
		end
	endtask

	// check what is out at this falling edge, then drive the next cycle
	task automatic cycle(input logic valid, input req_t req, input resp_t exp);
		logic  v;
		resp_t r;
		v = exp_valid_q.pop_front();
		r = exp_resp_q.pop_front();
		check_bit("resp_valid_o", resp_valid_o, v);
		if (v)
			check_resp("resp_o", resp_o, r);
		req_valid_i = valid;
		req_i       = valid ? req : '0;
		exp_valid_q.push_back(valid);
		exp_resp_q.push_back(exp);
		@(negedge clock_i);
	endtask

	task automatic idle(input int n);
		repeat (n) cycle(1'b0, '0, '0);
	endtask

	// explicit expected value while the model keeps in step
	task automatic send_req(input tag_t tag, input int grp, input resp_t exp);
		req_t  q;
		resp_t m;
		q.tag   = tag;
		q.group = group_t'(grp);
		model_step(q, m);
		cycle(1'b1, q, exp);
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	task automatic idle_then_pulse();
		idle(8);				// nothing may come out
		send_req(8'h5a, 5, make_resp(1'b0, 0, 5, 1'b0, 8'h00));
		idle(5);				// single pulse only
	endtask

	task automatic cold_fill();
		for (int i = 0; i < 4; i++)
			send_req(tag_t'(16 * (i + 1)), 3, make_resp(1'b0, i, 3, 1'b0, 8'h00));
		idle(3);
	endtask

	task automatic repeat_hits();
		for (int i = 0; i < 4; i++)
			send_req(tag_t'(16 * (i + 1)), 3, make_resp(1'b1, i, 3, 1'b0, 8'h00));
		idle(3);
	endtask

	task automatic evict_oldest();
		send_req(8'h50, 3, make_resp(1'b0, 0, 3, 1'b1, 8'h10));	// oldest goes first
		send_req(8'h60, 3, make_resp(1'b0, 1, 3, 1'b1, 8'h20));
		idle(3);
	endtask

	task automatic back_to_back();
		send_req(8'h77, 9, make_resp(1'b0, 0, 9, 1'b0, 8'h00));
		send_req(8'h77, 9, make_resp(1'b1, 0, 9, 1'b0, 8'h00));	// sees pending fill
		send_req(8'h78, 9, make_resp(1'b0, 1, 9, 1'b0, 8'h00));
		send_req(8'h79, 9, make_resp(1'b0, 2, 9, 1'b0, 8'h00));	// pointer forwarded
		send_req(8'h70, 3, make_resp(1'b0, 2, 3, 1'b1, 8'h30));
		send_req(8'h70, 3, make_resp(1'b1, 2, 3, 1'b0, 8'h00));
		idle(3);
	endtask

	// few groups and tags 0..7 so hits, misses and evictions mix
	task automatic random_stream();
		req_t  q;
		resp_t m;
		int    n;
		n = 0;
		while (n < RANDOM_REQS) begin
			lcg_state = lcg_next(lcg_state);
			if (lcg_state[31:30] == 2'd0)
				idle(1);			// gap now and then
			else begin
				q.group = group_t'(lcg_state[21:20]);
				q.tag   = tag_t'(lcg_state[18:16]);
				model_step(q, m);
				cycle(1'b1, q, m);
				n++;
			end
		end
		idle(3);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	initial begin
		clock_i     = 1'b0;
		resetn_i    = 1'b0;
		req_valid_i = 1'b0;
		req_i       = '0;
		errors      = 0;
		checks      = 0;
		lcg_state   = SEED;
		for (int g = 0; g < N_GROUPS; g++) begin
			model_ptr[g] = 0;
			for (int w = 0; w < N_WAYS; w++) begin
				model_valid[g][w] = 1'b0;
				model_tag[g][w]   = '0;
			end
		end
		repeat (3) begin
			exp_valid_q.push_back(1'b0);	// pipeline empty after reset
			exp_resp_q.push_back('0);
		end
		repeat (RESET_CYCLES) @(negedge clock_i);
		resetn_i = 1'b1;
		idle_then_pulse();
		cold_fill();
		repeat_hits();
		evict_oldest();
		back_to_back();
		random_stream();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog
	initial begin
		#((RUN_CYCLES + MARGIN) * 40);
		$display("watchdog expired after %0d cycles, tests did not complete",
			RUN_CYCLES + MARGIN);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- design/cache_defines.svh
// raw geometry of the cache tag directory
// pulled in by the geometry package
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// ----------------------------------------------------------------------------
// geometry
// total number of lines in the directory
`define CACHE_BLOCKS 64
// associativity of 2, 4 or 8 ways
`define CACHE_WAYS 4
// stored tag width
`define CACHE_TAG_BITS 8

// ceiling log2 for constant expressions
`define CLOG2(x) \
	(((x) <= 1)     ? 0  : ((x) <= 2)     ? 1  : ((x) <= 4)     ? 2  : \
	 ((x) <= 8)     ? 3  : ((x) <= 16)    ? 4  : ((x) <= 32)    ? 5  : \
	 ((x) <= 64)    ? 6  : ((x) <= 128)   ? 7  : ((x) <= 256)   ? 8  : \
	 ((x) <= 512)   ? 9  : ((x) <= 1024)  ? 10 : ((x) <= 2048)  ? 11 : \
	 ((x) <= 4096)  ? 12 : ((x) <= 8192)  ? 13 : ((x) <= 16384) ? 14 : \
	 ((x) <= 32768) ? 15 : 16)

`endif

//--- design/cache_geom_pkg.sv
// widths and vector types of the tag directory geometry
// block address form is {way, group}
`include "cache_defines.svh"

package cache_geom_pkg;

	// sizes
	localparam int N_BLOCKS   = `CACHE_BLOCKS;
	localparam int N_WAYS     = `CACHE_WAYS;
	localparam int N_GROUPS   = N_BLOCKS / N_WAYS;	// one fifo per group
	localparam int TAG_BITS   = `CACHE_TAG_BITS;

	// derived widths
	localparam int WAY_BITS   = `CLOG2(N_WAYS);
	localparam int GROUP_BITS = `CLOG2(N_GROUPS);
	localparam int ADDR_BITS  = WAY_BITS + GROUP_BITS;	// block addressable

	typedef logic [TAG_BITS-1:0]   tag_t;		// stored address tag
	typedef logic [GROUP_BITS-1:0] group_t;		// set index
	typedef logic [WAY_BITS-1:0]   way_t;		// way inside a set
	typedef logic [ADDR_BITS-1:0]  block_addr_t;	// {way, group}

endpackage

//--- design/cache_msg_pkg.sv
// messages passed between the directory blocks and to the outside
// request in, lookup and victim side by side, commit fed back, response out
package cache_msg_pkg;

	import cache_geom_pkg::*;

	// incoming request
	typedef struct packed {
		tag_t   tag;
		group_t group;			// set index
	} req_t;

	// registered tag compare plus stored state of every way for eviction
	typedef struct packed {
		logic                  hit;
		way_t                  hit_way;
		group_t                group;
		tag_t                  tag;		// request tag, carried along
		logic [N_WAYS-1:0]     victim_valid;
		tag_t [N_WAYS-1:0]     victim_tag;
	} lookup_t;

	typedef struct packed {
		way_t way;			// fifo pointer of the group
	} victim_t;

	// allocation that writes the tag array and advances the fifo pointer
	typedef struct packed {
		logic   en;
		group_t group;
		way_t   way;
		tag_t   tag;
	} commit_t;

	typedef struct packed {
		logic        hit;
		block_addr_t addr;		// {way, group}
		logic        evict_valid;
		tag_t        evict_tag;	// zero unless evict_valid
	} resp_t;

endpackage

//--- design/fifo_victim_select.sv
// fifo replacement pointer per group that gives the victim way of a request
// pointers move only when the resolver commits an allocation
module fifo_victim_select import cache_geom_pkg::*, cache_msg_pkg::*; (
	input  logic    clock_i,
	input  logic    resetn_i,
	input  logic    req_valid_i,
	input  req_t    req_i,		// only the group is used
	input  commit_t commit_i,
	output victim_t victim_o
);

	// ------------------------------------------------------------------------
	// pointer state
	way_t    ptr_q [N_GROUPS];	// one fifo counter per group
	logic    req_v_q;
	group_t  grp_q;
	logic    fwd;			// commit to the same group in flight
	way_t    next_way;
	victim_t victim_q;

	always_comb begin
		fwd      = commit_i.en && (commit_i.group == grp_q);
		// pointer advances at this same edge so take its new value
		next_way = fwd ? way_t'(commit_i.way + 1'b1) : ptr_q[grp_q];
	end

	// ------------------------------------------------------------------------
	// pointer update and request stage
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int g = 0; g < N_GROUPS; g++)
				ptr_q[g] <= '0;
			req_v_q <= 1'b0;
		end else begin
			req_v_q <= req_valid_i;
			// wraps at N_WAYS
			if (commit_i.en)
				ptr_q[commit_i.group] <= ptr_q[commit_i.group] + 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (req_valid_i)
			grp_q <= req_i.group;
		if (req_v_q)
			victim_q.way <= next_way;	// aligned with the lookup result
	end

	assign victim_o = victim_q;

	// resolver must allocate exactly where the fifo points
	a_commit_at_ptr: assert property (@(posedge clock_i) disable iff (!resetn_i)
		commit_i.en |-> commit_i.way == ptr_q[commit_i.group]);

endmodule

//--- design/set_cache_dir.sv
// top level of the set associative tag directory with fifo replacement
// one request per cycle with the response pulse two cycles after the request edge
module set_cache_dir import cache_msg_pkg::*; (
	input  logic  clock_i,
	input  logic  resetn_i,
	input  logic  req_valid_i,	// one cycle strobe
	input  req_t  req_i,
	output logic  resp_valid_o,	// one cycle pulse
	output resp_t resp_o
);

	logic    look_valid;
	lookup_t look;
	victim_t victim;
	commit_t commit;		// fed back to both side blocks

	// tag compare runs side by side with the fifo
	tag_lookup u_lookup (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.commit_i     (commit),
		.look_valid_o (look_valid),
		.look_o       (look)
	);

	fifo_victim_select u_victim (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.commit_i    (commit),
		.victim_o    (victim)
	);

	// picks hit or allocation and drives the outside
	way_resolve u_resolve (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.look_valid_i (look_valid),
		.look_i       (look),
		.victim_i     (victim),
		.commit_o     (commit),
		.resp_valid_o (resp_valid_o),
		.resp_o       (resp_o)
	);

endmodule

//--- design/tag_lookup.sv
// tag and valid storage of the directory with parallel way compare
// request registered at its edge with the result one cycle later
// a commit presented in the compare cycle is overlaid on the stored state
module tag_lookup import cache_geom_pkg::*, cache_msg_pkg::*; (
	input  logic    clock_i,
	input  logic    resetn_i,
	input  logic    req_valid_i,	// one cycle strobe
	input  req_t    req_i,
	input  commit_t commit_i,	// allocation from the resolver
	output logic    look_valid_o,
	output lookup_t look_o
);

	// ------------------------------------------------------------------------
	// storage indexed by {way, group}
	tag_t                tag_mem [N_BLOCKS];
	logic [N_BLOCKS-1:0] valid_q;

	logic                req_v_q;		// request stage
	req_t                req_q;
	logic [N_WAYS-1:0]   rd_valid;	// per way with commit overlaid
	tag_t [N_WAYS-1:0]   rd_tag;
	logic [N_WAYS-1:0]   hit_vec;
	way_t                hit_way;
	logic                look_valid_q;
	lookup_t             look_q;

	// ------------------------------------------------------------------------
	// compare all ways of the group
	always_comb begin
		block_addr_t line;
		hit_way = '0;
		for (int w = 0; w < N_WAYS; w++) begin
			line        = {way_t'(w), req_q.group};
			rd_valid[w] = valid_q[line];
			rd_tag[w]   = tag_mem[line];
			// pending write to this very line wins
			if (commit_i.en && commit_i.group == req_q.group &&
					commit_i.way == way_t'(w)) begin
				rd_valid[w] = 1'b1;
				rd_tag[w]   = commit_i.tag;
			end
			hit_vec[w] = rd_valid[w] && (rd_tag[w] == req_q.tag);
			if (hit_vec[w])
				hit_way = way_t'(w);	// at most one bit set
		end
	end

	// tag array write
	always_ff @(posedge clock_i) begin
		if (commit_i.en)
			tag_mem[{commit_i.way, commit_i.group}] <= commit_i.tag;
	end

	// control state
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q      <= '0;
			req_v_q      <= 1'b0;
			look_valid_q <= 1'b0;
		end else begin
			req_v_q      <= req_valid_i;
			look_valid_q <= req_v_q;
			if (commit_i.en)
				valid_q[{commit_i.way, commit_i.group}] <= 1'b1;
		end
	end

	// payload stages
	always_ff @(posedge clock_i) begin
		if (req_valid_i)
			req_q <= req_i;
		if (req_v_q) begin
			look_q.hit          <= |hit_vec;
			look_q.hit_way      <= hit_way;
			look_q.group        <= req_q.group;
			look_q.tag          <= req_q.tag;
			look_q.victim_valid <= rd_valid;	// resolver picks the victim line
			look_q.victim_tag   <= rd_tag;
		end
	end

	assign look_valid_o = look_valid_q;
	assign look_o       = look_q;

	// tags in a group stay unique only if allocation follows the miss path
	a_hit_onehot: assert property (@(posedge clock_i) disable iff (!resetn_i)
		req_v_q |-> $onehot0(hit_vec));

endmodule

//--- design/way_resolve.sv
// merges lookup and victim results into the response
// on a miss it also issues the commit back to both side blocks
// corrects for its own previous commit, which the side blocks have not seen
module way_resolve import cache_geom_pkg::*, cache_msg_pkg::*; (
	input  logic    clock_i,
	input  logic    resetn_i,
	input  logic    look_valid_i,
	input  lookup_t look_i,
	input  victim_t victim_i,
	output commit_t commit_o,
	output logic    resp_valid_o,
	output resp_t   resp_o
);

	logic              commit_en_q;
	group_t            commit_grp_q;
	way_t              commit_way_q;
	tag_t              commit_tag_q;
	logic              resp_valid_q;
	resp_t             resp_q;

	logic              same_grp;	// last commit hits this group
	logic              hit;
	way_t              way;		// chosen line
	way_t              vict_way;
	logic [N_WAYS-1:0] line_valid;
	tag_t [N_WAYS-1:0] line_tag;
	logic              evict;
	logic              tag_present;	// request tag held in a valid line

	// ------------------------------------------------------------------------
	// selection
	always_comb begin
		same_grp   = commit_en_q && (commit_grp_q == look_i.group);
		line_valid = look_i.victim_valid;
		line_tag   = look_i.victim_tag;
		hit        = look_i.hit;
		way        = look_i.hit_way;
		vict_way   = victim_i.way;
		if (same_grp) begin
			line_valid[commit_way_q] = 1'b1;
			line_tag[commit_way_q]   = commit_tag_q;
			vict_way                 = way_t'(commit_way_q + 1'b1);	// fifo moved on
			if (look_i.tag == commit_tag_q) begin
				hit = 1'b1;		// just allocated
				way = commit_way_q;
			end else if (look_i.hit && look_i.hit_way == commit_way_q)
				hit = 1'b0;		// that line was replaced
		end
		if (!hit)
			way = vict_way;
		evict = !hit && line_valid[way];
		// scan of the merged line state
		tag_present = 1'b0;
		for (int w = 0; w < N_WAYS; w++)
			if (line_valid[w] && line_tag[w] == look_i.tag)
				tag_present = 1'b1;
	end

	// ------------------------------------------------------------------------
	// response and commit registers
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			resp_valid_q <= 1'b0;
			commit_en_q  <= 1'b0;
		end else begin
			resp_valid_q <= look_valid_i;
			commit_en_q  <= look_valid_i && !hit;	// allocate on miss only
		end
	end

	always_ff @(posedge clock_i) begin
		if (look_valid_i) begin
			resp_q.hit         <= hit;
			resp_q.addr        <= {way, look_i.group};
			resp_q.evict_valid <= evict;
			resp_q.evict_tag   <= evict ? line_tag[way] : '0;
			commit_grp_q       <= look_i.group;
			commit_way_q       <= way;
			commit_tag_q       <= look_i.tag;
		end
	end

	assign commit_o = '{en: commit_en_q, group: commit_grp_q, way: commit_way_q,
		tag: commit_tag_q};
	assign resp_valid_o = resp_valid_q;
	assign resp_o       = resp_q;

	// a tag already stored in the group is never allocated again
	a_no_commit_on_hit: assert property (@(posedge clock_i) disable iff (!resetn_i)
		look_valid_i && tag_present |=> !commit_en_q);

endmodule

//--- run.sh
#!/bin/bash
# builds the tag directory testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f set_cache_dir.f \
	--top-module set_cache_dir_tb \
	-o sim_set_cache_dir

./obj_dir/sim_set_cache_dir | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

//--- set_cache_dir.f
+incdir+design
design/cache_geom_pkg.sv
design/cache_msg_pkg.sv
design/tag_lookup.sv
design/fifo_victim_select.sv
design/way_resolve.sv
design/set_cache_dir.sv
bench/set_cache_dir_tb.sv
